// ==== design/pext_pkg.sv ====
// Packed-SIMD multiply and divide unit definitions
// Data widths, saturation limits and the operation encoding

`default_nettype none

package pext_pkg;

  // Operand and result width
  localparam int XLEN = 32;

  // Kernel operand and signed 9x9 product widths
  localparam int BYTE_W     = 8;
  localparam int KER_PROD_W = 18;

  // Positive saturation values
  localparam logic [7:0]  Q7_MAX  = 8'h7f;
  localparam logic [15:0] Q15_MAX = 16'h7fff;

  typedef enum logic [2:0] {
    OP_KHM8,
    OP_KHMX8,
    OP_KHM16,
    OP_KHMX16,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU
  } muldiv_op_e;

endpackage

`default_nettype wire

// ==== design/div_pkg.sv ====
// Divider step encoding and bit counter definitions

`default_nettype none

package div_pkg;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_CHANGE_SIGN,
    DIV_FINISH
  } div_step_e;

  // Bit counter runs from the MSB down
  localparam int DIV_CNT_W = 5;
  localparam logic [DIV_CNT_W-1:0] DIV_LAST_BIT = 5'd31;

endpackage

`default_nettype wire

// ==== design/mult_prod_if.sv ====
// Partial products and saturation flags from the 8x8 kernels

`timescale 1ns/1ps
`default_nettype none

interface mult_prod_if;

  // Kernel 0 covers bytes 1:0, kernel 1 covers bytes 3:2
  logic [pext_pkg::KER_PROD_W-1:0] ker0_p00, ker0_p01, ker0_p10, ker0_p11;
  logic [pext_pkg::KER_PROD_W-1:0] ker1_p00, ker1_p01, ker1_p10, ker1_p11;
  logic [3:0]                      lane_sat;

  modport kernel (
    output ker0_p00, ker0_p01, ker0_p10, ker0_p11,
    output ker1_p00, ker1_p01, ker1_p10, ker1_p11, lane_sat
  );

  modport lanes (
    input ker0_p00, ker0_p01, ker0_p10, ker0_p11,
    input ker1_p00, ker1_p01, ker1_p10, ker1_p11, lane_sat
  );

endinterface

`default_nettype wire

// ==== design/div_step_if.sv ====
// Control and status between the divider FSM and its datapath

`timescale 1ns/1ps
`default_nettype none

interface div_step_if;

  div_pkg::div_step_e             step;
  logic [div_pkg::DIV_CNT_W-1:0]  counter;
  logic                           load_num_neg;
  logic                           load_den_neg;
  logic                           result_neg;
  logic                           is_div;
  logic                           greater_equal;
  logic                           den_zero;

  modport ctrl (
    output step, counter, load_num_neg, load_den_neg, result_neg, is_div,
    input  den_zero
  );

  modport dp (
    input  step, counter, load_num_neg, load_den_neg, result_neg, is_div,
    output greater_equal, den_zero
  );

endinterface

`default_nettype wire

// ==== design/mult_kernel.sv ====
// Operand lane routing and sign decode for the packed multiplies
// Eight signed 9x9 Baugh-Wooley kernel products and saturation detect

`timescale 1ns/1ps
`default_nettype none

module mult_kernel (
  input  pext_pkg::muldiv_op_e         op_i,
  input  logic [pext_pkg::XLEN-1:0]    op_a_i,
  input  logic [pext_pkg::XLEN-1:0]    op_b_i,
  mult_prod_if.kernel                  prod
);

  logic                          wide;
  logic                          crossed;
  logic                          is_mult;
  logic [3:0]                    sign_mask;
  logic [pext_pkg::XLEN-1:0]     b_routed;
  logic [pext_pkg::BYTE_W-1:0]   a_byte [4];
  logic [pext_pkg::BYTE_W-1:0]   b_byte [4];
  logic [pext_pkg::BYTE_W:0]     a_ext [4];
  logic [pext_pkg::BYTE_W:0]     b_ext [4];
  logic [3:0]                    a_min;
  logic [3:0]                    b_min;
  logic [3:0]                    sat8;
  logic [1:0]                    sat16;

  function automatic logic [pext_pkg::KER_PROD_W-1:0] smul(
    input logic [pext_pkg::BYTE_W:0] x,
    input logic [pext_pkg::BYTE_W:0] y
  );
    return $signed(x) * $signed(y);
  endfunction

  assign wide    = (op_i == pext_pkg::OP_KHM16) | (op_i == pext_pkg::OP_KHMX16);
  assign crossed = (op_i == pext_pkg::OP_KHMX8) | (op_i == pext_pkg::OP_KHMX16);
  assign is_mult = (op_i == pext_pkg::OP_KHM8) | (op_i == pext_pkg::OP_KHMX8) | wide;

  // X forms swap bytes within a halfword, or the two halfwords
  always_comb begin
    b_routed = op_b_i;
    if (crossed) begin
      if (wide) begin
        b_routed = {op_b_i[15:0], op_b_i[31:16]};
      end else begin
        b_routed = {op_b_i[23:16], op_b_i[31:24], op_b_i[7:0], op_b_i[15:8]};
      end
    end
  end

  // Only the upper byte of a halfword carries a sign
  assign sign_mask = wide ? 4'b1010 : 4'b1111;

  for (genvar i = 0; i < 4; i++) begin : g_byte
    assign a_byte[i] = op_a_i[i*pext_pkg::BYTE_W +: pext_pkg::BYTE_W];
    assign b_byte[i] = b_routed[i*pext_pkg::BYTE_W +: pext_pkg::BYTE_W];
    assign a_ext[i]  = {a_byte[i][pext_pkg::BYTE_W-1] & sign_mask[i], a_byte[i]};
    assign b_ext[i]  = {b_byte[i][pext_pkg::BYTE_W-1] & sign_mask[i], b_byte[i]};

    // 0x80 in both operands of a byte
    assign a_min[i] = a_byte[i][pext_pkg::BYTE_W-1] & ~|a_byte[i][pext_pkg::BYTE_W-2:0];
    assign b_min[i] = b_byte[i][pext_pkg::BYTE_W-1] & ~|b_byte[i][pext_pkg::BYTE_W-2:0];
    assign sat8[i]  = a_min[i] & b_min[i];
  end

  // 0x8000 needs a zero low byte on both sides
  assign sat16[0] = sat8[1] & ~|a_byte[0] & ~|b_byte[0];
  assign sat16[1] = sat8[3] & ~|a_byte[2] & ~|b_byte[2];

  assign prod.lane_sat = ~is_mult ? 4'b0000 :
                         wide     ? {{2{sat16[1]}}, {2{sat16[0]}}} : sat8;

  //////////////////////////////////////////////////
  // Kernel products
  //////////////////////////////////////////////////
  assign prod.ker0_p00 = smul(a_ext[0], b_ext[0]);
  assign prod.ker0_p01 = smul(a_ext[0], b_ext[1]);
  assign prod.ker0_p10 = smul(a_ext[1], b_ext[0]);
  assign prod.ker0_p11 = smul(a_ext[1], b_ext[1]);

  assign prod.ker1_p00 = smul(a_ext[2], b_ext[2]);
  assign prod.ker1_p01 = smul(a_ext[2], b_ext[3]);
  assign prod.ker1_p10 = smul(a_ext[3], b_ext[2]);
  assign prod.ker1_p11 = smul(a_ext[3], b_ext[3]);

endmodule

`default_nettype wire

// ==== design/mult_lanes.sv ====
// Kernel adders and Q7/Q15 result extraction
// Saturated lanes are forced to the positive limit

`timescale 1ns/1ps
`default_nettype none

module mult_lanes (
  input  pext_pkg::muldiv_op_e         op_i,
  mult_prod_if.lanes                   prod,
  output logic [pext_pkg::XLEN-1:0]    mult_result_o,
  output logic                         mult_ov_o
);

  logic                         wide;
  logic [pext_pkg::XLEN-1:0]    sum_lo;
  logic [pext_pkg::XLEN-1:0]    sum_hi;

  // Recombine the four byte products of one halfword
  function automatic logic [pext_pkg::XLEN-1:0] sum16(
    input logic [pext_pkg::KER_PROD_W-1:0] p00,
    input logic [pext_pkg::KER_PROD_W-1:0] p01,
    input logic [pext_pkg::KER_PROD_W-1:0] p10,
    input logic [pext_pkg::KER_PROD_W-1:0] p11
  );
    logic [pext_pkg::XLEN-1:0] s;
    s = {p11[15:0], 16'h0000}
      + {{6{p01[17]}}, p01, 8'h00}
      + {{6{p10[17]}}, p10, 8'h00}
      + {14'h0000, p00};
    return s;
  endfunction

  assign wide = (op_i == pext_pkg::OP_KHM16) | (op_i == pext_pkg::OP_KHMX16);

  assign sum_lo = sum16(prod.ker0_p00, prod.ker0_p01, prod.ker0_p10, prod.ker0_p11);
  assign sum_hi = sum16(prod.ker1_p00, prod.ker1_p01, prod.ker1_p10, prod.ker1_p11);

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////
  always_comb begin
    if (wide) begin
      mult_result_o[15:0]  = prod.lane_sat[0] ? pext_pkg::Q15_MAX : sum_lo[30:15];
      mult_result_o[31:16] = prod.lane_sat[2] ? pext_pkg::Q15_MAX : sum_hi[30:15];
    end else begin
      // Byte lanes use the direct products only
      mult_result_o[7:0]   = prod.lane_sat[0] ? pext_pkg::Q7_MAX : prod.ker0_p00[14:7];
      mult_result_o[15:8]  = prod.lane_sat[1] ? pext_pkg::Q7_MAX : prod.ker0_p11[14:7];
      mult_result_o[23:16] = prod.lane_sat[2] ? pext_pkg::Q7_MAX : prod.ker1_p00[14:7];
      mult_result_o[31:24] = prod.lane_sat[3] ? pext_pkg::Q7_MAX : prod.ker1_p11[14:7];
    end
  end

  assign mult_ov_o = |prod.lane_sat;

endmodule

`default_nettype wire

// ==== design/div_ctrl.sv ====
// Divider FSM with the bit counter
// Early finish on a zero divisor and result sign decisions

`timescale 1ns/1ps
`default_nettype none

module div_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  pext_pkg::muldiv_op_e  op_i,
  input  logic                  sign_a_i,
  input  logic                  sign_b_i,
  input  logic                  data_ind_timing_i,
  input  logic                  ready_i,
  div_step_if.ctrl              step,
  output logic                  valid_o
);

  div_pkg::div_step_e             state_q, state_d;
  logic [div_pkg::DIV_CNT_W-1:0]  cnt_q, cnt_d;
  logic                           by_zero_q, by_zero_d;
  logic                           is_signed;
  logic                           sign_a;
  logic                           sign_b;
  logic                           hold;

  assign is_signed = (op_i == pext_pkg::OP_DIV) | (op_i == pext_pkg::OP_REM);
  assign sign_a    = sign_a_i & is_signed;
  assign sign_b    = sign_b_i & is_signed;

  assign step.step         = state_q;
  assign step.counter      = cnt_q;
  assign step.is_div       = (op_i == pext_pkg::OP_DIV) | (op_i == pext_pkg::OP_DIVU);
  assign step.load_num_neg = sign_a;
  assign step.load_den_neg = sign_b;

  // Quotient by zero stays all ones, remainder follows the dividend
  assign step.result_neg = step.is_div ? (sign_a ^ sign_b) & ~by_zero_q : sign_a;

  // Result waits in FINISH for the consumer
  assign hold    = (state_q == div_pkg::DIV_FINISH) & ~ready_i;
  assign valid_o = (state_q == div_pkg::DIV_FINISH);

  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q - 1'b1;
    by_zero_d = by_zero_q;

    case (state_q)
      div_pkg::DIV_IDLE: begin
        state_d   = (!data_ind_timing_i && step.den_zero) ? div_pkg::DIV_FINISH
                                                          : div_pkg::DIV_ABS_A;
        by_zero_d = step.den_zero;
        cnt_d     = div_pkg::DIV_LAST_BIT;
      end
      div_pkg::DIV_ABS_A: begin
        state_d = div_pkg::DIV_ABS_B;
        cnt_d   = div_pkg::DIV_LAST_BIT;
      end
      div_pkg::DIV_ABS_B: begin
        state_d = div_pkg::DIV_COMP;
        cnt_d   = div_pkg::DIV_LAST_BIT;
      end
      div_pkg::DIV_COMP: begin
        // Bit 0 is resolved in LAST
        if (cnt_q == {{(div_pkg::DIV_CNT_W-1){1'b0}}, 1'b1}) begin
          state_d = div_pkg::DIV_LAST;
        end
      end
      div_pkg::DIV_LAST:        state_d = div_pkg::DIV_CHANGE_SIGN;
      div_pkg::DIV_CHANGE_SIGN: state_d = div_pkg::DIV_FINISH;
      div_pkg::DIV_FINISH:      state_d = div_pkg::DIV_IDLE;
      default:                  state_d = div_pkg::DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= div_pkg::DIV_IDLE;
      cnt_q     <= '0;
      by_zero_q <= 1'b0;
    end else if (start_i && !hold) begin
      state_q   <= state_d;
      cnt_q     <= cnt_d;
      by_zero_q <= by_zero_d;
    end
  end

endmodule

`default_nettype wire

// ==== design/div_datapath.sv ====
// Restoring divider datapath with one shared subtract adder
// Remainder register doubles as the result register

`timescale 1ns/1ps
`default_nettype none

module div_datapath (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [pext_pkg::XLEN-1:0]    op_a_i,
  input  logic [pext_pkg::XLEN-1:0]    op_b_i,
  div_step_if.dp                       step,
  output logic [pext_pkg::XLEN-1:0]    div_result_o
);

  logic [pext_pkg::XLEN-1:0]      rem_q;
  logic [pext_pkg::XLEN-1:0]      den_q;
  logic [pext_pkg::XLEN-1:0]      num_q;
  logic [pext_pkg::XLEN-1:0]      quo_q;
  logic [pext_pkg::XLEN-1:0]      adder_a;
  logic [pext_pkg::XLEN-1:0]      adder_b;
  logic [pext_pkg::XLEN-1:0]      diff;
  logic [pext_pkg::XLEN-1:0]      one_shift;
  logic [pext_pkg::XLEN-1:0]      next_rem;
  logic [pext_pkg::XLEN-1:0]      next_quo;
  logic [div_pkg::DIV_CNT_W-1:0]  bit_idx;

  //////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////
  always_comb begin
    adder_a = '0;
    adder_b = op_b_i;
    case (step.step)
      div_pkg::DIV_ABS_A: adder_b = op_a_i;
      div_pkg::DIV_COMP,
      div_pkg::DIV_LAST: begin
        adder_a = rem_q;
        adder_b = den_q;
      end
      // Negate the finished quotient or remainder
      div_pkg::DIV_CHANGE_SIGN: adder_b = rem_q;
      default: ;
    endcase
  end

  assign diff = adder_a - adder_b;

  // Unsigned compare from the MSBs and the difference sign
  assign step.greater_equal = (rem_q[pext_pkg::XLEN-1] == den_q[pext_pkg::XLEN-1])
                              ? ~diff[pext_pkg::XLEN-1] : rem_q[pext_pkg::XLEN-1];
  assign step.den_zero      = ~|op_b_i;

  assign one_shift = {{(pext_pkg::XLEN-1){1'b0}}, 1'b1} << step.counter;
  assign next_rem  = step.greater_equal ? diff : rem_q;
  assign next_quo  = step.greater_equal ? (quo_q | one_shift) : quo_q;
  assign bit_idx   = step.counter - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q <= '0;
      den_q <= '0;
      num_q <= '0;
      quo_q <= '0;
    end else begin
      case (step.step)
        // Preset the divide by zero result
        div_pkg::DIV_IDLE: rem_q <= step.is_div ? '1 : op_a_i;
        div_pkg::DIV_ABS_A: begin
          num_q <= step.load_num_neg ? diff : op_a_i;
          quo_q <= '0;
        end
        div_pkg::DIV_ABS_B: begin
          rem_q <= {{(pext_pkg::XLEN-1){1'b0}}, num_q[pext_pkg::XLEN-1]};
          den_q <= step.load_den_neg ? diff : op_b_i;
        end
        div_pkg::DIV_COMP: begin
          rem_q <= {next_rem[pext_pkg::XLEN-2:0], num_q[bit_idx]};
          quo_q <= next_quo;
        end
        div_pkg::DIV_LAST: rem_q <= step.is_div ? next_quo : next_rem;
        div_pkg::DIV_CHANGE_SIGN: begin
          if (step.result_neg) begin
            rem_q <= diff;
          end
        end
        default: ;
      endcase
    end
  end

  assign div_result_o = rem_q;

endmodule

`default_nettype wire

// ==== design/pext_muldiv_top.sv ====
// Packed-SIMD multiply and divide unit top level
// Multiply path is combinational, divider is iterative

`timescale 1ns/1ps
`default_nettype none

module pext_muldiv_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         en_i,
  input  pext_pkg::muldiv_op_e         op_i,
  input  logic [pext_pkg::XLEN-1:0]    op_a_i,
  input  logic [pext_pkg::XLEN-1:0]    op_b_i,
  input  logic                         data_ind_timing_i,
  input  logic                         ready_i,
  output logic [pext_pkg::XLEN-1:0]    result_o,
  output logic                         valid_o,
  output logic                         set_ov_o
);

  logic                        is_div_op;
  logic                        div_valid;
  logic                        mult_ov;
  logic [pext_pkg::XLEN-1:0]   mult_result;
  logic [pext_pkg::XLEN-1:0]   div_result;

  mult_prod_if u_prod_if ();
  div_step_if  u_step_if ();

  assign is_div_op = (op_i == pext_pkg::OP_DIV) | (op_i == pext_pkg::OP_DIVU) |
                     (op_i == pext_pkg::OP_REM) | (op_i == pext_pkg::OP_REMU);

  //////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////
  mult_kernel u_mult_kernel (
    .op_i   (op_i),
    .op_a_i (op_a_i),
    .op_b_i (op_b_i),
    .prod   (u_prod_if.kernel)
  );

  mult_lanes u_mult_lanes (
    .op_i          (op_i),
    .prod          (u_prod_if.lanes),
    .mult_result_o (mult_result),
    .mult_ov_o     (mult_ov)
  );

  //////////////////////////////////////////////////
  // Divider
  //////////////////////////////////////////////////
  div_ctrl u_div_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .start_i           (en_i & is_div_op),
    .op_i              (op_i),
    .sign_a_i          (op_a_i[pext_pkg::XLEN-1]),
    .sign_b_i          (op_b_i[pext_pkg::XLEN-1]),
    .data_ind_timing_i (data_ind_timing_i),
    .ready_i           (ready_i),
    .step              (u_step_if.ctrl),
    .valid_o           (div_valid)
  );

  div_datapath u_div_datapath (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .step         (u_step_if.dp),
    .div_result_o (div_result)
  );

  // Multiplies are valid in the request cycle
  assign valid_o  = is_div_op ? div_valid : en_i;
  assign result_o = is_div_op ? div_result : mult_result;
  assign set_ov_o = mult_ov & en_i;

endmodule

`default_nettype wire

// ==== dv/pext_muldiv_props.sv ====
// Concurrent assertions on the multiply and divide unit ports

`timescale 1ns/1ps
`default_nettype none

module pext_muldiv_props (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         en_i,
  input pext_pkg::muldiv_op_e         op_i,
  input logic                         ready_i,
  input logic [pext_pkg::XLEN-1:0]    result_o,
  input logic                         valid_o,
  input logic                         set_ov_o
);

  logic is_mult;

  assign is_mult = (op_i == pext_pkg::OP_KHM8) | (op_i == pext_pkg::OP_KHMX8) |
                   (op_i == pext_pkg::OP_KHM16) | (op_i == pext_pkg::OP_KHMX16);

  // No result without a request
  a_valid_needs_en: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !en_i |-> !valid_o
  ) else $error("valid_o high while en_i is low");

  // Stalled result must not move
  a_result_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (valid_o && !ready_i) |=> $stable(result_o)
  ) else $error("result_o changed while stalled");

  a_ov_mult_only: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $rose(set_ov_o) |-> is_mult
  ) else $error("set_ov_o rose for a divide op");

  a_ov_with_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) set_ov_o |-> valid_o
  ) else $error("set_ov_o high without valid_o");

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
// Testbench clock and reset generator
// 100 ns clock, reset held low for the first four cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    // Release away from the active edge
    @(negedge clk_o);
    rst_no = 1'b1;
  end

  always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== dv/tb_pext_muldiv.sv ====
// Testbench for the packed-SIMD multiply and divide unit
// Directed and random requests, reference model, checker and timeout

`timescale 1ns/1ps
`default_nettype none

module tb_pext_muldiv;

  // 80 requests of at most 40 cycles each, plus margin
  localparam int N_REQ       = 80;
  localparam int MAX_REQ_CYC = 40;
  localparam int MAX_CYCLES  = N_REQ * MAX_REQ_CYC + 100;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       en_i;
  pext_pkg::muldiv_op_e       op_i;
  logic [pext_pkg::XLEN-1:0]  op_a_i;
  logic [pext_pkg::XLEN-1:0]  op_b_i;
  logic                       data_ind_timing_i;
  logic                       ready_i;
  logic [pext_pkg::XLEN-1:0]  result_o;
  logic                       valid_o;
  logic                       set_ov_o;

  integer                     seed;
  int                         cycles;
  int                         n_issued;
  int                         n_taken;
  logic [pext_pkg::XLEN-1:0]  exp_res;
  logic                       exp_ov;

  tb_clkgen u_clkgen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  pext_muldiv_top u_pext_muldiv_top (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .en_i              (en_i),
    .op_i              (op_i),
    .op_a_i            (op_a_i),
    .op_b_i            (op_b_i),
    .data_ind_timing_i (data_ind_timing_i),
    .ready_i           (ready_i),
    .result_o          (result_o),
    .valid_o           (valid_o),
    .set_ov_o          (set_ov_o)
  );

  bind pext_muldiv_top pext_muldiv_props u_props (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (en_i),
    .op_i     (op_i),
    .ready_i  (ready_i),
    .result_o (result_o),
    .valid_o  (valid_o),
    .set_ov_o (set_ov_o)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic is_mult_op(input pext_pkg::muldiv_op_e op);
    return (op == pext_pkg::OP_KHM8) || (op == pext_pkg::OP_KHMX8) ||
           (op == pext_pkg::OP_KHM16) || (op == pext_pkg::OP_KHMX16);
  endfunction

  function automatic logic [pext_pkg::XLEN-1:0] ref_result(
    input  pext_pkg::muldiv_op_e       op,
    input  logic [pext_pkg::XLEN-1:0]  a,
    input  logic [pext_pkg::XLEN-1:0]  b,
    output logic                       ov
  );
    logic [pext_pkg::XLEN-1:0] res;
    logic signed [7:0]         a8;
    logic signed [7:0]         b8;
    logic signed [15:0]        a16;
    logic signed [15:0]        b16;
    logic signed [15:0]        p16;
    logic signed [31:0]        p32;
    logic signed [31:0]        sa;
    logic signed [31:0]        sb;
    logic                      crossed;
    logic                      div_ovf;
    int                        i;
    res     = '0;
    ov      = 1'b0;
    sa      = a;
    sb      = b;
    crossed = (op == pext_pkg::OP_KHMX8) || (op == pext_pkg::OP_KHMX16);
    div_ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      pext_pkg::OP_KHM8, pext_pkg::OP_KHMX8: begin
        for (i = 0; i < 4; i++) begin
          a8 = a[8*i +: 8];
          // X form pairs each byte with its neighbour in the halfword
          b8 = crossed ? b[8*(i^1) +: 8] : b[8*i +: 8];
          p16 = a8 * b8;
          if (a8 == 8'h80 && b8 == 8'h80) begin
            res[8*i +: 8] = 8'h7f;
            ov = 1'b1;
          end else begin
            res[8*i +: 8] = p16[14:7];
          end
        end
      end
      pext_pkg::OP_KHM16, pext_pkg::OP_KHMX16: begin
        for (i = 0; i < 2; i++) begin
          a16 = a[16*i +: 16];
          b16 = crossed ? b[16*(1-i) +: 16] : b[16*i +: 16];
          p32 = a16 * b16;
          if (a16 == 16'h8000 && b16 == 16'h8000) begin
            res[16*i +: 16] = 16'h7fff;
            ov = 1'b1;
          end else begin
            res[16*i +: 16] = p32[30:15];
          end
        end
      end
      pext_pkg::OP_DIV: begin
        if (b == '0) begin
          res = '1;
        end else if (div_ovf) begin
          res = a;
        end else begin
          // Signed quotient, truncated toward zero
          res = sa / sb;
        end
      end
      pext_pkg::OP_DIVU: res = (b == '0) ? '1 : a / b;
      pext_pkg::OP_REM: begin
        if (b == '0) begin
          res = a;
        end else if (div_ovf) begin
          res = '0;
        end else begin
          // Remainder takes the sign of the dividend
          res = sa % sb;
        end
      end
      default:           res = (b == '0) ? a : a % b;
    endcase
    return res;
  endfunction

  // Cycles from request to the first valid_o
  function automatic int ref_latency(
    input pext_pkg::muldiv_op_e       op,
    input logic [pext_pkg::XLEN-1:0]  b,
    input logic                       dit
  );
    if (is_mult_op(op)) begin
      return 1;
    end
    if (b == '0 && !dit) begin
      return 2;
    end
    // Setup, 31 compare steps, then last, sign and finish
    return 3 + 31 + 3;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_result(
    input logic [pext_pkg::XLEN-1:0] got,
    input logic [pext_pkg::XLEN-1:0] exp
  );
    if (got !== exp) begin
      $display("ERROR at %0t: result_o = 0x%08h, expected 0x%08h (op %s)",
               $time, got, exp, op_i.name());
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_ov(input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t: set_ov_o = %b, expected %b (op %s)",
               $time, got, exp, op_i.name());
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      $display("ERROR at %0t: valid_o latency = %0d, expected %0d (op %s)",
               $time, got, exp, op_i.name());
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Every valid cycle is checked mid-cycle, where outputs are settled
  always @(negedge clk_i) begin
    if (rst_ni && en_i && valid_o) begin
      exp_res = ref_result(op_i, op_a_i, op_b_i, exp_ov);
      check_result(result_o, exp_res);
      check_ov(set_ov_o, exp_ov);
      if (ready_i) begin
        n_taken++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  task automatic issue(
    input pext_pkg::muldiv_op_e       op,
    input logic [pext_pkg::XLEN-1:0]  a,
    input logic [pext_pkg::XLEN-1:0]  b,
    input logic                       dit,
    input int                         stall
  );
    int lat;
    @(posedge clk_i);
    en_i              <= 1'b1;
    op_i              <= op;
    op_a_i            <= a;
    op_b_i            <= b;
    data_ind_timing_i <= dit;
    ready_i           <= (stall == 0);
    n_issued++;
    lat = 1;
    @(negedge clk_i);
    while (!valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    check_latency(lat, ref_latency(op, b, dit));
    if (stall != 0) begin
      // Hold the consumer off, then take the result once
      repeat (stall) @(posedge clk_i);
      ready_i <= 1'b1;
      @(negedge clk_i);
    end
  endtask

  task automatic idle(input int n);
    @(posedge clk_i);
    en_i    <= 1'b0;
    ready_i <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  initial begin : stimulus
    logic [pext_pkg::XLEN-1:0] a;
    logic [pext_pkg::XLEN-1:0] b;
    logic [31:0]               rnd;
    logic [2:0]                code;
    int                        k;
    seed              = 69;
    cycles            = 0;
    n_issued          = 0;
    n_taken           = 0;
    en_i              <= 1'b0;
    op_i              <= pext_pkg::OP_KHM8;
    op_a_i            <= '0;
    op_b_i            <= '0;
    data_ind_timing_i <= 1'b0;
    ready_i           <= 1'b0;
    wait (rst_ni === 1'b1);

    // Random packed multiplies, all four ops
    for (k = 0; k < 24; k++) begin
      code = {1'b0, k[1:0]};
      a = $random(seed);
      b = $random(seed);
      issue(pext_pkg::muldiv_op_e'(code), a, b, 1'b0, 0);
    end
    idle(2);

    // Saturating lanes next to ordinary ones
    issue(pext_pkg::OP_KHM8,   32'h8012_8080, 32'h8080_8005, 1'b0, 0);
    issue(pext_pkg::OP_KHMX8,  32'h8080_0080, 32'h807f_8011, 1'b0, 0);
    issue(pext_pkg::OP_KHM16,  32'h8000_8000, 32'h8000_1234, 1'b0, 0);
    issue(pext_pkg::OP_KHMX16, 32'h1234_8000, 32'h8000_4321, 1'b0, 0);
    idle(2);

    // Random divides, some with small divisors
    for (k = 0; k < 24; k++) begin
      code = {1'b1, k[1:0]};
      rnd = $random(seed);
      a = $random(seed);
      b = $random(seed);
      if (k % 3 == 1) begin
        b = {{20{b[31]}}, b[31:20]};
      end
      issue(pext_pkg::muldiv_op_e'(code), a, b, rnd[0], 0);
    end

    // Most negative value divided by -1
    issue(pext_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0, 0);
    issue(pext_pkg::OP_REM, 32'h8000_0000, 32'hffff_ffff, 1'b0, 0);
    idle(2);

    // Divide by zero, early finish and full length
    for (k = 0; k < 8; k++) begin
      code = {1'b1, k[1:0]};
      a = $random(seed);
      issue(pext_pkg::muldiv_op_e'(code), a, '0, k[2], 0);
    end
    idle(2);

    // Back-pressure on random ops
    for (k = 0; k < 18; k++) begin
      rnd = $random(seed);
      code = rnd[2:0];
      a = $random(seed);
      b = $random(seed);
      if (code[2] && rnd[3]) begin
        b = {24'h000000, b[7:0]};
      end
      issue(pext_pkg::muldiv_op_e'(code), a, b, rnd[6], 1 + (rnd[5:4] % 3));
    end
    idle(3);

    if (n_taken != n_issued) begin
      $display("Results taken (%0d) do not match requests issued (%0d)",
               n_taken, n_issued);
      $display("Test failed");
      $fatal(1);
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
design/pext_pkg.sv
design/div_pkg.sv
design/mult_prod_if.sv
design/div_step_if.sv
design/mult_kernel.sv
design/mult_lanes.sv
design/div_ctrl.sv
design/div_datapath.sv
design/pext_muldiv_top.sv
dv/pext_muldiv_props.sv
dv/tb_clkgen.sv
dv/tb_pext_muldiv.sv
